// File: Makefile
# Verilator build and run for the coprocessor testbench

VERILATOR ?= verilator
TOP       ?= copro_tb
FILELIST  ?= copro.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard common/*.sv common/*.svh hdl/*.sv sequencer/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/copro_defines.svh
`ifndef COPRO_DEFINES_SVH
`define COPRO_DEFINES_SVH

// ===========================================================================
// Datapath widths
// ===========================================================================
`define COPRO_WORD_W      64   // Register and store data
`define COPRO_INSTR_W     32   // One program word
`define COPRO_IMM_W       15   // Immediate field, sign extended on use
`define COPRO_REG_SEL_W   4    // Register number, r0 reads zero

// ===========================================================================
// Address spaces and depths
// ===========================================================================
`define COPRO_IP_W        10   // 1024 program words
`define COPRO_ADR_W       16   // Store address space
`define COPRO_STACK_DEPTH 16   // Return addresses

`endif

// File: common/copro_pkg.sv
`default_nettype none

`include "copro_defines.svh"

package copro_pkg;

	typedef logic [`COPRO_WORD_W-1:0]    word_t;     // Register value
	typedef logic [`COPRO_IP_W-1:0]      iaddr_t;    // Program address
	typedef logic [`COPRO_ADR_W-1:0]     addr_t;     // Store address
	typedef logic [`COPRO_REG_SEL_W-1:0] reg_sel_t;  // Register number

	// Opcodes keep the encodings of the larger core
	typedef enum logic [4:0] {
		OP_NOP    = 5'd0,
		OP_WAIT   = 5'd1,
		OP_JCC    = 5'd4,
		OP_JMP    = 5'd9,
		OP_STORE  = 5'd17,
		OP_STOREI = 5'd18,
		OP_SHL    = 5'd20,
		OP_SHR    = 5'd21,
		OP_ADD    = 5'd22,
		OP_AND    = 5'd24,
		OP_OR     = 5'd25,
		OP_XOR    = 5'd26
	} opcode_t;

	// Branch condition, carried in the rd field of a JCC
	typedef enum logic [3:0] {
		JEQ = 4'd0,
		JNE = 4'd1,
		JLT = 4'd2,
		JLE = 4'd3,
		JGE = 4'd4,
		JGT = 4'd5
	} cond_t;

	// JMP subcodes, also in rd
	localparam logic [3:0] JMP_REG = 4'd0;
	localparam logic [3:0] JMP_JSR = 4'd1;
	localparam logic [3:0] JMP_RET = 4'd2;

	typedef struct packed {
		logic [`COPRO_IMM_W-1:0] imm;  // Top of the word
		reg_sel_t                rs2;
		reg_sel_t                rs1;
		reg_sel_t                rd;   // Also condition or JMP subcode
		opcode_t                 opcode;
	} instr_t;

	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_exec,
		st_halt
	} seq_state_t;

	typedef struct packed {
		addr_t adr;
		word_t dat;
	} store_t;

endpackage

`default_nettype wire

// File: copro.f
+incdir+common
common/copro_pkg.sv
hdl/copro_prog_ram.sv
sequencer/copro_call_stack.sv
sequencer/copro_sequencer.sv
hdl/copro_regfile.sv
hdl/copro_alu.sv
hdl/copro_top.sv
dv/copro_tb.sv

// File: dv/copro_input.txt
// Header: name (ASCII hex), max instruction count, runs, program words, expected stores
// Then program pairs (address instruction) and expected store pairs (address data)

// ALU ops with positive and negative immediates, run twice
616C75 14 2 10 6
000 00C80036  001 FFFA0056  002 000A4276  003 00206011
004 01E04498  005 00228011  006 FE0002B9  007 0024A011
008 00AA42DA  009 0026C011  00A 000802F4  00B 0028E011
00C 00060116  00D FFF10535  00E 002B2011  00F 00000001
0010 0000000000000066  0011 00000000000000F0  0012 FFFFFFFFFFFFFF64
0013 FFFFFFFFFFFFFFCC  0014 0000000000000640  0015 0000001FFFFFFFFF

// r0 reads zero, STOREI data and address truncation
72305F73746F7265 A 1 7 3
000 02460016  001 00400011  002 02460036  003 00180234
004 008A0352  005 FFFC01F2  006 00000001
0020 0  3045 A  FFFE F

// Signed JCC, a store marks each branch not taken
6A6363 1C 1 1C 6
000 FFF60036  001 00060056  002 00060076  003 000A6404
004 00600012  005 000E4204  006 00620032  007 00124224
008 00640052  009 00166424  00A 00660072  00B 001A4244
00C 00680092  00D 001E2444  00E 006A00B2  00F 00226464
010 006C00D2  011 00262464  012 006E00F2  013 002A2484
014 00700112  015 002E4284  016 00720132  017 003224A4
018 00740152  019 003664A4  01A 00760172  01B 00000001
0031 1  0033 3  0035 5  0037 7  0039 9  003B B

// JMP with offset, nested JSR and RET, run twice
6A756D70 10 2 E 5
000 00100036  001 FFF80209  002 00800032  003 00000001
004 00820052  005 00140029  006 008800B2  007 00000001
00A 00840072  00B 000C0229  00C 00860092  00D 00000049
00E 008A00D2  00F 00000049
0041 2  0042 3  0045 6  0043 4  0044 5

// End of tests
0

// File: dv/copro_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "copro_defines.svh"

module copro_tb;

	localparam int STIM_WORDS = 512;   // Flat word stream from the data file

	logic                clk;
	logic                rst;
	logic                prog_we;
	copro_pkg::iaddr_t   prog_adr;
	copro_pkg::instr_t   prog_dat;
	logic                run;
	logic                store_valid;
	copro_pkg::store_t   store;
	logic                done;

	logic [63:0]         stim [STIM_WORDS];
	copro_pkg::store_t   seen [$];          // Stores of the current run
	int                  errors      = 0;
	int                  run_cycles  = 0;   // Cycles with run_i high
	int                  cycle_limit = 0;

	copro_top UUT (
		.clk           (clk),
		.rst           (rst),
		.prog_we_i     (prog_we),
		.prog_adr_i    (prog_adr),
		.prog_dat_i    (prog_dat),
		.run_i         (run),
		.store_valid_o (store_valid),
		.store_o       (store),
		.done_o        (done)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;   // 40 ns period

	// Watchdog over all runs
	always @(posedge clk) begin
		if (run)
			run_cycles++;
		if (run_cycles > cycle_limit) begin
			$display("Timeout: program did not reach WAIT within %0d cycles", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// Host writes, address and word pairs starting at first
	task automatic write_program(input int first, input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			prog_we  <= 1'b1;
			prog_adr <= stim[first + 2*i][`COPRO_IP_W-1:0];
			prog_dat <= stim[first + 2*i + 1][`COPRO_INSTR_W-1:0];
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	// One run from address 0 until done_o, then rewind
	task automatic run_program();
		int idle;
		idle = int'($urandom % 8);
		repeat (idle) @(posedge clk);
		seen.delete();
		@(posedge clk);
		run <= 1'b1;
		forever begin
			@(negedge clk);
			if (store_valid)
				seen.push_back(store);
			if (done)
				break;
		end
		@(posedge clk);
		run <= 1'b0;
		@(posedge clk);   // Sequencer leaves st_halt on this edge
		@(negedge clk);
		check_value("done_o", 64'd0, 64'(done));
	endtask

	task automatic compare_stores(input int first, input int count);
		if (seen.size() < count) begin
			$display("Missing stores: expected %0d, saw %0d", count, seen.size());
			errors++;
		end else if (seen.size() > count) begin
			$display("Extra stores: expected %0d, saw %0d", count, seen.size());
			errors++;
		end
		for (int i = 0; i < count && i < seen.size(); i++) begin
			check_value("store_o.adr", stim[first + 2*i], 64'(seen[i].adr));
			check_value("store_o.dat", stim[first + 2*i + 1], seen[i].dat);
		end
	endtask

	// ===========================================================================
	// Main sequence
	// ===========================================================================
	initial begin
		int          pos;
		int          nprog;
		int          nexp;
		int          runs;
		int          errors_before;
		int          tests_run;
		int          tests_failed;
		logic [63:0] name;

		rst      = 1'b1;
		prog_we  = 1'b0;
		prog_adr = '0;
		prog_dat = '0;
		run      = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(32'h999d70f6));
		$readmemh("dv/copro_input.txt", stim);

		// Header: name, max count, runs, program words, expected stores
		pos = 0;
		while (stim[pos] != 64'd0) begin
			cycle_limit += int'(stim[pos+2]) * (2 * int'(stim[pos+1]) + 20);
			pos += 5 + 2 * int'(stim[pos+3]) + 2 * int'(stim[pos+4]);
		end
		if (pos == 0) begin
			$display("No tests could be read from dv/copro_input.txt");
			errors++;
		end

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("store_valid_o", 64'd0, 64'(store_valid));
		check_value("done_o", 64'd0, 64'(done));
		$display("reset: %s", (errors == 0) ? "PASS" : "FAIL");

		pos = 0;
		while (stim[pos] != 64'd0) begin
			name          = stim[pos];
			runs          = int'(stim[pos+2]);
			nprog         = int'(stim[pos+3]);
			nexp          = int'(stim[pos+4]);
			errors_before = errors;
			pos += 5;
			write_program(pos, nprog);   // run_i is low here
			pos += 2 * nprog;
			for (int r = 0; r < runs; r++) begin   // Reruns must repeat the stream
				run_program();
				compare_stores(pos, nexp);
			end
			pos += 2 * nexp;
			tests_run++;
			if (errors == errors_before) begin
				$display("test %s: PASS (%0d runs)", name, runs);
			end else begin
				$display("test %s: FAIL (%0d errors)", name, errors - errors_before);
				tests_failed++;
			end
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/copro_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "copro_defines.svh"

module copro_alu (
	input  wire copro_pkg::instr_t instr_i,
	input  wire copro_pkg::word_t  a_i,
	input  wire copro_pkg::word_t  b_i,
	output copro_pkg::word_t       result_o,
	output logic                   taken_o    // JCC decision
);

	copro_pkg::word_t simm;     // Sign-extended immediate
	logic [4:0]       shamt;
	copro_pkg::cond_t cond;

	assign simm  = {{(`COPRO_WORD_W-`COPRO_IMM_W){instr_i.imm[`COPRO_IMM_W-1]}}, instr_i.imm};
	assign shamt = b_i[4:0] | instr_i.imm[4:0];   // Either source can give the count
	assign cond  = copro_pkg::cond_t'(instr_i.rd);

	always_comb begin
		case (instr_i.opcode)
		copro_pkg::OP_ADD: result_o = a_i + b_i + simm;
		copro_pkg::OP_AND: result_o = a_i & b_i & simm;
		copro_pkg::OP_OR:  result_o = a_i | b_i | simm;
		copro_pkg::OP_XOR: result_o = a_i ^ b_i ^ simm;
		copro_pkg::OP_SHL: result_o = a_i << shamt;
		copro_pkg::OP_SHR: result_o = a_i >> shamt;   // Logical
		// Effective address for stores and register jumps
		copro_pkg::OP_STORE, copro_pkg::OP_STOREI, copro_pkg::OP_JMP:
			result_o = a_i + simm;
		default: result_o = '0;
		endcase
	end

	// ===========================================================================
	// Branch condition, signed compares
	// ===========================================================================
	always_comb begin
		taken_o = 1'b0;
		if (instr_i.opcode == copro_pkg::OP_JCC) begin
			case (cond)
			copro_pkg::JEQ: taken_o = (a_i == b_i);
			copro_pkg::JNE: taken_o = (a_i != b_i);
			copro_pkg::JLT: taken_o = ($signed(a_i) <  $signed(b_i));
			copro_pkg::JLE: taken_o = ($signed(a_i) <= $signed(b_i));
			copro_pkg::JGE: taken_o = ($signed(a_i) >= $signed(b_i));
			copro_pkg::JGT: taken_o = ($signed(a_i) >  $signed(b_i));
			default:        taken_o = 1'b0;   // Unused codes never branch
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/copro_prog_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "copro_defines.svh"

module copro_prog_ram (
	input  wire logic              clk,
	input  wire logic              prog_we_i,
	input  wire copro_pkg::iaddr_t prog_adr_i,
	input  wire copro_pkg::instr_t prog_dat_i,
	input  wire copro_pkg::iaddr_t fetch_adr_i,
	output copro_pkg::instr_t      fetch_instr_o   // One clock after fetch_adr_i
);

	localparam int WORDS = 2 ** `COPRO_IP_W;

	copro_pkg::instr_t mem [WORDS];   // Inferred block RAM

	// Host write port
	always_ff @(posedge clk) begin
		if (prog_we_i) begin
			mem[prog_adr_i] <= prog_dat_i;
		end
	end

	// Registered fetch port, read latency 1
	always_ff @(posedge clk) begin
		fetch_instr_o <= mem[fetch_adr_i];
	end

endmodule

`default_nettype wire

// File: hdl/copro_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "copro_defines.svh"

module copro_regfile (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire copro_pkg::reg_sel_t rs1_i,
	input  wire copro_pkg::reg_sel_t rs2_i,
	input  wire logic                wb_en_i,
	input  wire copro_pkg::reg_sel_t wb_sel_i,
	input  wire copro_pkg::word_t    wb_dat_i,
	output copro_pkg::word_t         a_o,
	output copro_pkg::word_t         b_o
);

	localparam int NREG = 2 ** `COPRO_REG_SEL_W;

	copro_pkg::word_t regs [1:NREG-1];   // No storage behind r0

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < NREG; i++)
				regs[i] <= '0;
		end else if (wb_en_i && (wb_sel_i != '0)) begin   // r0 writes vanish
			regs[wb_sel_i] <= wb_dat_i;
		end
	end

	// Combinational read ports
	assign a_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign b_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: hdl/copro_top.sv
`timescale 1ns/1ps
`default_nettype none

module copro_top (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               prog_we_i,    // Host program write
	input  wire copro_pkg::iaddr_t  prog_adr_i,
	input  wire copro_pkg::instr_t  prog_dat_i,
	input  wire logic               run_i,        // Level, low stops and rewinds
	output logic                    store_valid_o,
	output copro_pkg::store_t       store_o,
	output logic                    done_o
);

	copro_pkg::iaddr_t   fetch_adr;
	copro_pkg::instr_t   fetch_instr;   // Current instruction during st_exec
	copro_pkg::word_t    a, b;          // Register operands
	copro_pkg::word_t    result;
	logic                taken;
	logic                wb_en;
	copro_pkg::reg_sel_t wb_sel;
	copro_pkg::word_t    wb_dat;

	copro_prog_ram u_prog_ram (
		.clk           (clk),
		.prog_we_i     (prog_we_i),
		.prog_adr_i    (prog_adr_i),
		.prog_dat_i    (prog_dat_i),
		.fetch_adr_i   (fetch_adr),
		.fetch_instr_o (fetch_instr)
	);

	copro_sequencer u_sequencer (
		.clk           (clk),
		.rst           (rst),
		.run_i         (run_i),
		.instr_i       (fetch_instr),
		.result_i      (result),
		.taken_i       (taken),
		.b_i           (b),
		.fetch_adr_o   (fetch_adr),
		.wb_en_o       (wb_en),
		.wb_sel_o      (wb_sel),
		.wb_dat_o      (wb_dat),
		.store_valid_o (store_valid_o),
		.store_o       (store_o),
		.done_o        (done_o)
	);

	// Source selects straight from the instruction fields
	copro_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.rs1_i    (fetch_instr.rs1),
		.rs2_i    (fetch_instr.rs2),
		.wb_en_i  (wb_en),
		.wb_sel_i (wb_sel),
		.wb_dat_i (wb_dat),
		.a_o      (a),
		.b_o      (b)
	);

	copro_alu u_alu (
		.instr_i  (fetch_instr),
		.a_i      (a),
		.b_i      (b),
		.result_o (result),
		.taken_o  (taken)
	);

endmodule

`default_nettype wire

// File: sequencer/copro_call_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "copro_defines.svh"

module copro_call_stack #(
	parameter int DEPTH = `COPRO_STACK_DEPTH
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              push_i,       // JSR
	input  wire logic              pop_i,        // RET
	input  wire copro_pkg::iaddr_t push_adr_i,
	output copro_pkg::iaddr_t      top_o         // Last pushed address
);

	localparam int SP_W  = $clog2(DEPTH + 1);   // Counts 0..DEPTH entries
	localparam int IDX_W = $clog2(DEPTH);

	copro_pkg::iaddr_t stack [DEPTH];   // Return addresses only
	logic [SP_W-1:0]   sp;              // Number of entries held
	logic [IDX_W-1:0]  top_idx;

	assign top_idx = IDX_W'(sp - 1'b1);
	assign top_o   = stack[top_idx];

	always_ff @(posedge clk) begin
		if (rst)
			sp <= '0;
		else if (push_i)
			sp <= sp + 1'b1;
		else if (pop_i)
			sp <= sp - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (push_i)
			stack[sp[IDX_W-1:0]] <= push_adr_i;   // Next free slot
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push_i |-> (sp != SP_W'(DEPTH)));
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop_i |-> (sp != '0));
	a_one_op: assert property (@(posedge clk) disable iff (rst)
		!(push_i && pop_i));

endmodule

`default_nettype wire

// File: sequencer/copro_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "copro_defines.svh"

module copro_sequencer (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               run_i,
	input  wire copro_pkg::instr_t  instr_i,      // Valid in st_exec
	input  wire copro_pkg::word_t   result_i,     // ALU result or a+simm
	input  wire logic               taken_i,      // JCC decision
	input  wire copro_pkg::word_t   b_i,          // Store data
	output copro_pkg::iaddr_t       fetch_adr_o,
	output logic                    wb_en_o,
	output copro_pkg::reg_sel_t     wb_sel_o,
	output copro_pkg::word_t        wb_dat_o,
	output logic                    store_valid_o,
	output copro_pkg::store_t       store_o,
	output logic                    done_o
);

	copro_pkg::seq_state_t state;
	copro_pkg::iaddr_t     ip;
	copro_pkg::iaddr_t     ip_inc;
	copro_pkg::iaddr_t     stack_top;   // Return address for RET
	logic                  exec;        // Instruction executes this cycle
	logic                  is_alu;
	logic                  is_store;
	logic                  is_jsr;
	logic                  is_ret;

	// ===========================================================================
	// Decode
	// ===========================================================================
	assign exec     = (state == copro_pkg::st_exec) && run_i;
	assign ip_inc   = ip + 1'b1;
	assign is_alu   = instr_i.opcode inside {copro_pkg::OP_SHL, copro_pkg::OP_SHR,
		copro_pkg::OP_ADD, copro_pkg::OP_AND, copro_pkg::OP_OR, copro_pkg::OP_XOR};
	assign is_store = instr_i.opcode inside {copro_pkg::OP_STORE, copro_pkg::OP_STOREI};
	assign is_jsr   = (instr_i.opcode == copro_pkg::OP_JMP) && (instr_i.rd == copro_pkg::JMP_JSR);
	assign is_ret   = (instr_i.opcode == copro_pkg::OP_JMP) && (instr_i.rd == copro_pkg::JMP_RET);

	assign fetch_adr_o = ip;   // Sampled by the RAM at the end of st_fetch
	assign wb_en_o     = exec && is_alu;
	assign wb_sel_o    = instr_i.rd;    // r0 writes dropped in the register file
	assign wb_dat_o    = result_i;
	assign done_o      = (state == copro_pkg::st_halt);

	copro_call_stack u_call_stack (
		.clk        (clk),
		.rst        (rst),
		.push_i     (exec && is_jsr),
		.pop_i      (exec && is_ret),
		.push_adr_i (ip_inc),         // Return to the word after the JSR
		.top_o      (stack_top)
	);

	// ===========================================================================
	// Fetch / execute FSM and instruction pointer
	// ===========================================================================
	always_ff @(posedge clk) begin
		if (rst || !run_i) begin   // Run low rewinds to address 0
			state <= copro_pkg::st_idle;
			ip    <= '0;
		end else begin
			case (state)
			copro_pkg::st_idle: begin
				state <= copro_pkg::st_fetch;
				ip    <= '0;
			end
			copro_pkg::st_fetch:
				state <= copro_pkg::st_exec;
			copro_pkg::st_exec: begin
				state <= copro_pkg::st_fetch;   // Next fetch uses the new ip, no bubble
				ip    <= ip_inc;
				case (instr_i.opcode)
				copro_pkg::OP_WAIT: begin
					state <= copro_pkg::st_halt;
					ip    <= ip;
				end
				copro_pkg::OP_JCC:
					if (taken_i)
						ip <= instr_i.imm[`COPRO_IP_W-1:0];   // Absolute target
				copro_pkg::OP_JMP:
					case (instr_i.rd)
					copro_pkg::JMP_REG, copro_pkg::JMP_JSR:
						ip <= result_i[`COPRO_IP_W-1:0];   // a + simm
					copro_pkg::JMP_RET:
						ip <= stack_top;
					default: ;   // Unknown subcode falls through
					endcase
				default: ;
				endcase
			end
			copro_pkg::st_halt: ;   // Held until run_i falls
			default:
				state <= copro_pkg::st_idle;
			endcase
		end
	end

	// ===========================================================================
	// Store strobe, one cycle after st_exec
	// ===========================================================================
	always_ff @(posedge clk) begin
		if (rst)
			store_valid_o <= 1'b0;
		else
			store_valid_o <= exec && is_store;
	end

	always_ff @(posedge clk) begin
		if (exec && is_store) begin
			store_o.adr <= result_i[`COPRO_ADR_W-1:0];   // Truncated a + simm
			if (instr_i.opcode == copro_pkg::OP_STORE)
				store_o.dat <= b_i;
			else
				store_o.dat <= {{(`COPRO_WORD_W-`COPRO_REG_SEL_W){1'b0}}, instr_i.rd};
		end
	end

	// Every instruction spends a fetch cycle, so strobes never touch
	a_store_gap: assert property (@(posedge clk) disable iff (rst)
		store_valid_o |=> !store_valid_o);

endmodule

`default_nettype wire
